// File: source/lsu_pkg.sv
// Shared types for the load/store unit and its two-bank data TCM
// Operation flags are one-hot, and at most one flag is set per packet
// No address range or alignment checking anywhere in the unit

package lsu_pkg;

	// Data path width and bytes per doubleword
	localparam int XLEN = 64;
	localparam int NB = XLEN / 8;

	// Rename-buffer index bits inside the destination tag
	localparam int RB_W = 2;
	// Destination tag, 5 register bits plus rename index
	localparam int RD_W = 5 + RB_W;

	// One-hot operation flags from decode
	typedef struct packed {
		logic lb;
		logic lh;
		logic lw;
		logic ld;
		logic lbu;
		logic lhu;
		logic lwu;
		logic sb;
		logic sh;
		logic sw;
		logic sd;
		// Fences retire with a zero result
		logic fence_i;
		logic fence;
	} lsu_ops_t;

	// Execute packet, op1 is the byte address and op2 the store data
	typedef struct packed {
		lsu_ops_t ops;
		logic [RD_W-1:0] rd;
		logic [XLEN-1:0] op1;
		logic [XLEN-1:0] op2;
	} lsu_exeparam_t;

	// Writeback payload
	typedef struct packed {
		logic [RD_W-1:0] rd;
		logic [XLEN-1:0] res;
	} lsu_wb_t;

	// One bank access
	typedef struct packed {
		// Full line index, truncated by the bank to its own depth
		logic [XLEN-1:0] line;
		logic wen;
		// One bit per byte lane
		logic [NB-1:0] wmask;
		logic [XLEN-1:0] wdata;
	} bank_req_t;

	// Load format held for one cycle until the bank data returns
	typedef struct packed {
		// Access width, one-hot
		logic w_byte;
		logic w_half;
		logic w_word;
		logic w_dword;
		// Zero extension instead of sign extension
		logic uns;
		// Byte offset inside the doubleword
		logic [2:0] align;
		// Address bit 3, access starts in bank B
		logic odd;
	} load_fmt_t;

endpackage

// File: source/dtcm.sv
// One bank of the data TCM, 2^AW doublewords with byte write enables
// Read is registered and write-first, line bits above AW are ignored
// Contents are undefined until written
`timescale 1ns/1ps

module dtcm import lsu_pkg::*; #(
	parameter int AW = 8
) (
	input logic CLK,
	input bank_req_t req,
	output logic [XLEN-1:0] rdata
);

	// Storage, one doubleword per line
	logic [XLEN-1:0] mem [2**AW];

	// Line select, wraps inside the bank
	logic [AW-1:0] line;

	assign line = req.line[AW-1:0];

	// Per byte lane, write and read in the same edge
	always_ff @(posedge CLK) begin
		for (int i = 0; i < NB; i++) begin
			if (req.wen && req.wmask[i]) begin
				mem[line][i*8 +: 8] <= req.wdata[i*8 +: 8];
				// Written lane returns the new byte
				rdata[i*8 +: 8] <= req.wdata[i*8 +: 8];
			end else begin
				// Untouched lane returns the stored byte
				rdata[i*8 +: 8] <= mem[line][i*8 +: 8];
			end
		end
	end

endmodule

// File: source/store_align.sv
// Splits one execute packet into the two bank requests
// An access may span up to 16 bytes across bank A and bank B
// Write enables only for a valid store, loads and fences just read
`timescale 1ns/1ps

module store_align import lsu_pkg::*; (
	input logic exeparam_valid,
	input lsu_exeparam_t exeparam,
	output bank_req_t bank_a_req,
	output bank_req_t bank_b_req
);

	logic is_store;
	logic [2:0] align;
	logic odd;
	logic [XLEN-1:0] line;
	logic [2*NB-1:0] mask;
	logic [2*XLEN-1:0] data;
	logic [NB-1:0] wmask_a;
	logic [NB-1:0] wmask_b;
	logic [XLEN-1:0] wdata_a;
	logic [XLEN-1:0] wdata_b;

	// Any store width
	assign is_store = exeparam.ops.sb | exeparam.ops.sh | exeparam.ops.sw | exeparam.ops.sd;

	// Byte offset and bank select from the address
	assign align = exeparam.op1[2:0];
	assign odd = exeparam.op1[3];

	// Line index is address bits 4 and up
	assign line = {4'b0000, exeparam.op1[XLEN-1:4]};

	// 16-byte window mask, width pattern shifted by the byte offset
	assign mask = ({2*NB{exeparam.ops.sb}} & (16'h0001 << align))
		| ({2*NB{exeparam.ops.sh}} & (16'h0003 << align))
		| ({2*NB{exeparam.ops.sw}} & (16'h000f << align))
		| ({2*NB{exeparam.ops.sd}} & (16'h00ff << align));

	// Store data moved to the same byte lanes
	assign data = {{XLEN{1'b0}}, exeparam.op2} << {align, 3'b000};

	// Odd start, low window half goes to bank B
	assign {wmask_b, wmask_a} = odd ? {mask[NB-1:0], mask[2*NB-1:NB]} : mask;
	assign {wdata_b, wdata_a} = odd ? {data[XLEN-1:0], data[2*XLEN-1:XLEN]} : data;

	always_comb begin
		// Bank A holds the following even doubleword on an odd start
		bank_a_req.line = odd ? line + XLEN'(1) : line;
		bank_a_req.wen = exeparam_valid & is_store;
		bank_a_req.wmask = wmask_a;
		bank_a_req.wdata = wdata_a;
	end

	always_comb begin
		// Bank B always uses the address line
		bank_b_req.line = line;
		bank_b_req.wen = exeparam_valid & is_store;
		bank_b_req.wmask = wmask_b;
		bank_b_req.wdata = wdata_b;
	end

endmodule

// File: source/load_align.sv
// Load result formatting from the two registered bank outputs
// Format is captured at issue and used in the following cycle
// Result is zero for stores, fences and idle cycles
`timescale 1ns/1ps

module load_align import lsu_pkg::*; (
	input logic CLK,
	input logic rst_n,
	input lsu_ops_t ops,
	input logic [3:0] addr_low,
	input logic [XLEN-1:0] rdata_a,
	input logic [XLEN-1:0] rdata_b,
	output logic [XLEN-1:0] res
);

	load_fmt_t fmt_d;
	load_fmt_t fmt_q;
	logic [2*XLEN-1:0] window;
	logic [XLEN-1:0] field;

	// Signed and unsigned flavours fold into width plus unsigned flag
	always_comb begin
		fmt_d.w_byte = ops.lb | ops.lbu;
		fmt_d.w_half = ops.lh | ops.lhu;
		fmt_d.w_word = ops.lw | ops.lwu;
		fmt_d.w_dword = ops.ld;
		fmt_d.uns = ops.lbu | ops.lhu | ops.lwu;
		fmt_d.align = addr_low[2:0];
		fmt_d.odd = addr_low[3];
	end

	// Held until the bank data is back
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			fmt_q <= '0;
		end else begin
			fmt_q <= fmt_d;
		end
	end

	// Rebuild the 16-byte window in address order
	assign window = fmt_q.odd ? {rdata_a, rdata_b} : {rdata_b, rdata_a};

	// Field starts at the byte offset
	assign field = XLEN'(window >> {fmt_q.align, 3'b000});

	// Width select and extension
	always_comb begin
		res = '0;
		if (fmt_q.w_byte) begin
			res = fmt_q.uns ? {{XLEN-8{1'b0}}, field[7:0]}
				: {{XLEN-8{field[7]}}, field[7:0]};
		end else if (fmt_q.w_half) begin
			res = fmt_q.uns ? {{XLEN-16{1'b0}}, field[15:0]}
				: {{XLEN-16{field[15]}}, field[15:0]};
		end else if (fmt_q.w_word) begin
			res = fmt_q.uns ? {{XLEN-32{1'b0}}, field[31:0]}
				: {{XLEN-32{field[31]}}, field[31:0]};
		end else if (fmt_q.w_dword) begin
			res = field;
		end
	end

endmodule

// File: source/lsu.sv
// Load/store unit with a two-bank data TCM, fixed one-cycle latency
// No back-pressure, a packet is taken on every cycle with valid high
// Flush drops the writeback only, a flushed store still writes memory
`timescale 1ns/1ps

module lsu import lsu_pkg::*; #(
	// Line address bits per bank
	parameter int AW = 8
) (
	input logic CLK,
	input logic rst_n,
	input logic exeparam_valid,
	input lsu_exeparam_t exeparam,
	input logic flush,
	output logic wb_valid,
	output lsu_wb_t wb
);

	bank_req_t bank_a_req;
	bank_req_t bank_b_req;
	logic [XLEN-1:0] rdata_a;
	logic [XLEN-1:0] rdata_b;
	logic [XLEN-1:0] load_res;
	logic retire;
	logic [RD_W-1:0] wb_rd;

	// Bank requests from the issuing packet
	store_align u_store_align (
		.exeparam_valid(exeparam_valid),
		.exeparam(exeparam),
		.bank_a_req(bank_a_req),
		.bank_b_req(bank_b_req)
	);

	// Even doublewords
	dtcm #(
		.AW(AW)
	) u_bank_a (
		.CLK(CLK),
		.req(bank_a_req),
		.rdata(rdata_a)
	);

	// Odd doublewords
	dtcm #(
		.AW(AW)
	) u_bank_b (
		.CLK(CLK),
		.req(bank_b_req),
		.rdata(rdata_b)
	);

	// Load format captured here, result valid one cycle later
	load_align u_load_align (
		.CLK(CLK),
		.rst_n(rst_n),
		.ops(exeparam.ops),
		.addr_low(exeparam.op1[3:0]),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b),
		.res(load_res)
	);

	// Only an unflushed packet retires
	assign retire = exeparam_valid & ~flush;

	// Writeback valid and tag, one cycle behind issue
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_rd <= '0;
		end else begin
			wb_valid <= retire;
			wb_rd <= exeparam.rd;
		end
	end

	// Result straight from the aligner, no extra register
	assign wb = '{rd: wb_rd, res: load_res};

endmodule

// File: verif/lsu_assert.sv
// Writeback and bank enable checks, bound into every lsu instance
// Expects the fixed one-cycle writeback of lsu
`timescale 1ns/1ps

module lsu_assert import lsu_pkg::*; (
	input logic CLK,
	input logic rst_n,
	input logic exeparam_valid,
	input lsu_exeparam_t exeparam,
	input logic flush,
	input logic wb_valid,
	input lsu_wb_t wb,
	input bank_req_t bank_a_req,
	input bank_req_t bank_b_req
);

	// Synchronous reset, valid is clear one edge after rst_n is seen low
	reset_quiet: assert property (@(posedge CLK) !rst_n |=> !wb_valid)
		else $error("wb_valid high after a reset cycle");

	// Writeback only for an unflushed packet one cycle back
	retire_source: assert property (@(posedge CLK) disable iff (!rst_n)
		wb_valid |-> $past(exeparam_valid && !flush))
		else $error("wb_valid without a retiring packet in the previous cycle");

	// Tag of the packet issued one cycle back
	retire_tag: assert property (@(posedge CLK) disable iff (!rst_n)
		wb_valid |-> wb.rd == $past(exeparam.rd))
		else $error("wb.rd differs from the issued tag");

	// Banks never written on an idle cycle
	idle_no_write: assert property (@(posedge CLK)
		!exeparam_valid |-> !bank_a_req.wen && !bank_b_req.wen)
		else $error("bank write enable without exeparam_valid");

endmodule

bind lsu lsu_assert u_lsu_assert (
	.CLK(CLK),
	.rst_n(rst_n),
	.exeparam_valid(exeparam_valid),
	.exeparam(exeparam),
	.flush(flush),
	.wb_valid(wb_valid),
	.wb(wb),
	.bank_a_req(bank_a_req),
	.bank_b_req(bank_b_req)
);

// File: verif/lsu_tb.sv
// Self-checking testbench for lsu, one table entry issued per clock
// Directed entries carry literal results, the random tail uses a byte model
// Memory is never loaded before the bytes are written
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 5;
	localparam int MARGIN_CYCLES = 20;
	localparam int DRIVE_DELAY = 2;
	// Random tail region and length
	localparam logic [XLEN-1:0] RAND_BASE = 64'h800;
	localparam int RAND_PAIRS = 32;

	// Op flags, lb is the top bit and fence the bottom
	localparam lsu_ops_t OP_NONE = 13'h0000;
	localparam lsu_ops_t OP_LB = 13'h1000;
	localparam lsu_ops_t OP_LH = 13'h0800;
	localparam lsu_ops_t OP_LW = 13'h0400;
	localparam lsu_ops_t OP_LD = 13'h0200;
	localparam lsu_ops_t OP_LBU = 13'h0100;
	localparam lsu_ops_t OP_LHU = 13'h0080;
	localparam lsu_ops_t OP_LWU = 13'h0040;
	localparam lsu_ops_t OP_SB = 13'h0020;
	localparam lsu_ops_t OP_SH = 13'h0010;
	localparam lsu_ops_t OP_SW = 13'h0008;
	localparam lsu_ops_t OP_SD = 13'h0004;
	localparam lsu_ops_t OP_FENCE_I = 13'h0002;
	localparam lsu_ops_t OP_FENCE = 13'h0001;

	// One issued packet and what it must retire as
	typedef struct packed {
		lsu_ops_t ops;
		logic [RD_W-1:0] rd;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] data;
		logic flush;
		logic exp_valid;
		logic [XLEN-1:0] exp_res;
	} entry_t;

	logic CLK = 1'b0;
	logic rst_n;
	logic exeparam_valid;
	lsu_exeparam_t exeparam;
	logic flush;
	logic wb_valid;
	lsu_wb_t wb;

	entry_t table_q [$];
	// Byte image of the random region
	logic [7:0] model [4096];
	integer seed;
	int unsigned timeout;

	lsu #(
		.AW(8)
	) u_lsu (
		.CLK(CLK),
		.rst_n(rst_n),
		.exeparam_valid(exeparam_valid),
		.exeparam(exeparam),
		.flush(flush),
		.wb_valid(wb_valid),
		.wb(wb)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	task automatic compare(input string what, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Valid is implied by any op flag, tag follows the table position
	task automatic add_entry(input lsu_ops_t ops, input logic [XLEN-1:0] addr,
		input logic [XLEN-1:0] data, input logic flushed, input logic [XLEN-1:0] exp_res);
		entry_t e;
		e.ops = ops;
		e.rd = RD_W'(table_q.size() * 3 + 1);
		e.addr = addr;
		e.data = data;
		e.flush = flushed;
		e.exp_valid = (ops != OP_NONE) && !flushed;
		e.exp_res = exp_res;
		table_q.push_back(e);
	endtask

	// Little endian, lowest byte at the address
	task automatic model_store(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
		for (int b = 0; b < NB; b++) begin
			model[addr[11:0] + 12'(b)] = data[b*8 +: 8];
		end
	endtask

	function automatic logic [XLEN-1:0] model_load(input logic [XLEN-1:0] addr);
		logic [XLEN-1:0] res;
		for (int b = 0; b < NB; b++) begin
			res[b*8 +: 8] = model[addr[11:0] + 12'(b)];
		end
		return res;
	endfunction

	task automatic build_table();
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] data;
		int unsigned off;
		// Aligned doubleword, then every load width
		add_entry(OP_SD, 64'h100, 64'h7f01_a2b3_c45d_e6f7, 1'b0, 64'h0);
		add_entry(OP_LD, 64'h100, 64'h0, 1'b0, 64'h7f01_a2b3_c45d_e6f7);
		add_entry(OP_LB, 64'h100, 64'h0, 1'b0, 64'hffff_ffff_ffff_fff7);
		add_entry(OP_LBU, 64'h100, 64'h0, 1'b0, 64'h0000_0000_0000_00f7);
		add_entry(OP_LB, 64'h102, 64'h0, 1'b0, 64'h0000_0000_0000_005d);
		add_entry(OP_LH, 64'h100, 64'h0, 1'b0, 64'hffff_ffff_ffff_e6f7);
		add_entry(OP_LHU, 64'h100, 64'h0, 1'b0, 64'h0000_0000_0000_e6f7);
		add_entry(OP_LH, 64'h106, 64'h0, 1'b0, 64'h0000_0000_0000_7f01);
		add_entry(OP_LW, 64'h100, 64'h0, 1'b0, 64'hffff_ffff_c45d_e6f7);
		add_entry(OP_LWU, 64'h100, 64'h0, 1'b0, 64'h0000_0000_c45d_e6f7);
		add_entry(OP_LW, 64'h104, 64'h0, 1'b0, 64'h0000_0000_7f01_a2b3);
		// Across address bit 3, bank A then bank B on one line
		add_entry(OP_SD, 64'h205, 64'h1122_3344_5566_7788, 1'b0, 64'h0);
		add_entry(OP_LD, 64'h205, 64'h0, 1'b0, 64'h1122_3344_5566_7788);
		add_entry(OP_LW, 64'h206, 64'h0, 1'b0, 64'h0000_0000_4455_6677);
		add_entry(OP_LH, 64'h207, 64'h0, 1'b0, 64'h0000_0000_0000_5566);
		// Across the 16-byte line, bank B then bank A of the next line
		add_entry(OP_SD, 64'h21b, 64'hfedc_ba98_7654_3210, 1'b0, 64'h0);
		add_entry(OP_LD, 64'h21b, 64'h0, 1'b0, 64'hfedc_ba98_7654_3210);
		add_entry(OP_LW, 64'h21e, 64'h0, 1'b0, 64'hffff_ffff_dcba_9876);
		add_entry(OP_LHU, 64'h21f, 64'h0, 1'b0, 64'h0000_0000_0000_ba98);
		add_entry(OP_SH, 64'h22f, 64'h0000_0000_0000_a55a, 1'b0, 64'h0);
		add_entry(OP_LH, 64'h22f, 64'h0, 1'b0, 64'hffff_ffff_ffff_a55a);
		// Narrow stores into an earlier doubleword
		add_entry(OP_SD, 64'h300, 64'h0706_0504_0302_0100, 1'b0, 64'h0);
		add_entry(OP_SB, 64'h303, 64'hffff_ffff_ffff_ffaa, 1'b0, 64'h0);
		add_entry(OP_SH, 64'h306, 64'h1234_5678_9abc_bbcc, 1'b0, 64'h0);
		add_entry(OP_LD, 64'h300, 64'h0, 1'b0, 64'hbbcc_0504_aa02_0100);
		add_entry(OP_SW, 64'h301, 64'h0000_0000_dead_beef, 1'b0, 64'h0);
		add_entry(OP_LD, 64'h300, 64'h0, 1'b0, 64'hbbcc_05de_adbe_ef00);
		// Flushed store still lands in memory
		add_entry(OP_SD, 64'h400, 64'h0123_4567_89ab_cdef, 1'b1, 64'h0);
		add_entry(OP_LD, 64'h400, 64'h0, 1'b0, 64'h0123_4567_89ab_cdef);
		add_entry(OP_LB, 64'h407, 64'h0, 1'b1, 64'h0);
		add_entry(OP_LBU, 64'h407, 64'h0, 1'b0, 64'h0000_0000_0000_0001);
		add_entry(OP_LB, 64'h400, 64'h0, 1'b0, 64'hffff_ffff_ffff_ffef);
		// Fences and idle slots
		add_entry(OP_FENCE, 64'h0, 64'h0, 1'b0, 64'h0);
		add_entry(OP_NONE, 64'h0, 64'h0, 1'b0, 64'h0);
		add_entry(OP_FENCE_I, 64'h0, 64'h0, 1'b0, 64'h0);
		add_entry(OP_SW, 64'h500, 64'h0000_0000_ffff_ffff, 1'b0, 64'h0);
		add_entry(OP_LWU, 64'h500, 64'h0, 1'b0, 64'h0000_0000_ffff_ffff);
		add_entry(OP_LW, 64'h500, 64'h0, 1'b0, 64'hffff_ffff_ffff_ffff);
		// Random tail, stores 7 bytes apart so every byte below the last is written
		for (int i = 0; i < RAND_PAIRS; i++) begin
			data = {$random(seed), $random(seed)};
			addr = RAND_BASE + 64'(i * 7);
			model_store(addr, data);
			add_entry(OP_SD, addr, data, 1'b0, 64'h0);
			// Any fully written doubleword so far
			off = $unsigned($random(seed)) % (i * 7 + 1);
			addr = RAND_BASE + 64'(off);
			add_entry(OP_LD, addr, 64'h0, 1'b0, model_load(addr));
		end
	endtask

	// Store pattern with valid low, the banks must stay untouched
	task automatic drive_idle();
		exeparam_valid = 1'b0;
		exeparam = '{ops: OP_SD, rd: '0, op1: 64'h600, op2: '1};
		flush = 1'b0;
	endtask

	task automatic drive_entry(input entry_t e);
		if (e.ops == OP_NONE) begin
			drive_idle();
		end else begin
			exeparam_valid = 1'b1;
			exeparam = '{ops: e.ops, rd: e.rd, op1: e.addr, op2: e.data};
			flush = e.flush;
		end
	endtask

	task automatic check_retire(input int idx, input entry_t e);
		compare($sformatf("entry %0d wb_valid", idx), XLEN'(wb_valid), XLEN'(e.exp_valid));
		if (e.exp_valid) begin
			compare($sformatf("entry %0d wb.rd", idx), XLEN'(wb.rd), XLEN'(e.rd));
			compare($sformatf("entry %0d wb.res", idx), wb.res, e.exp_res);
		end
	endtask

	initial begin
		seed = 32'h733202a3;
		rst_n = 1'b0;
		// Live load with a nonzero tag, reset must keep it from retiring
		exeparam_valid = 1'b1;
		exeparam = '{ops: OP_LD, rd: '1, op1: 64'h100, op2: '0};
		flush = 1'b0;
		build_table();
		repeat (RESET_CYCLES) @(posedge CLK);
		#(DRIVE_DELAY);
		compare("wb_valid in reset", XLEN'(wb_valid), '0);
		compare("wb.rd in reset", XLEN'(wb.rd), '0);
		rst_n = 1'b1;
		drive_idle();
		// Entry i-1 has retired at the edge where entry i is issued
		for (int i = 0; i < table_q.size(); i++) begin
			@(posedge CLK);
			#(DRIVE_DELAY);
			if (i > 0) begin
				check_retire(i - 1, table_q[i - 1]);
			end
			drive_entry(table_q[i]);
		end
		@(posedge CLK);
		#(DRIVE_DELAY);
		check_retire(table_q.size() - 1, table_q[table_q.size() - 1]);
		drive_idle();
		@(posedge CLK);
		#(DRIVE_DELAY);
		compare("wb_valid when idle", XLEN'(wb_valid), '0);
		$display("TB PASSED");
		$finish;
	end

	// Table is built at time zero, limit follows its length
	initial begin
		#1;
		timeout = (table_q.size() + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;
		#(timeout);
		$display("Timeout: the run did not finish within %0d ns", timeout);
		$display("TB FAILED");
		$fatal(1, "Watchdog expired");
	end

endmodule

// File: filelist.f
source/lsu_pkg.sv
source/dtcm.sv
source/store_align.sv
source/load_align.sv
source/lsu.sv
verif/lsu_assert.sv
verif/lsu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the lsu testbench with Verilator
# Exit status is 0 only when the run log holds no failure

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
	--top-module lsu_tb \
	-Mdir obj_dir \
	-f filelist.f > "$BUILD_LOG" 2>&1
build_status=$?
cat "$BUILD_LOG"
if [ $build_status -ne 0 ]; then
	echo "Build failed with status $build_status"
	exit 1
fi

./obj_dir/Vlsu_tb > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q "TB FAILED" "$SIM_LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if ! grep -q "TB PASSED" "$SIM_LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi

echo "Simulation passed"
exit 0
